/* hw/vsaPkg.sv */
// vsa shared definitions
package vsaPkg;

    // datapath geometry
    localparam int dataWidth    = 5;                  // register and data bus width
    localparam int pcWidth      = 5;                  // fetch address width
    localparam int instrWidth   = 12;                 // instruction word width
    localparam int regCount     = 4;                  // r0 plus three general registers
    localparam int regAddrWidth = $clog2(regCount);   // register select field width
    localparam int pcStep       = 2;                  // pc advance per instruction

    // five control states, one clock each
    typedef enum logic [2:0] {
        IF  = 3'd0,   // fetch
        ID  = 3'd1,   // decode and operand read
        EX  = 3'd2,   // execute
        MEM = 3'd3,   // memory access and pc update
        WB  = 3'd4    // register write-back
    } vsaState_e;

    // major opcode, 6 and 7 unused
    typedef enum logic [2:0] {
        opLw     = 3'd0,
        opSw     = 3'd1,
        opBeqz   = 3'd2,
        opAluReg = 3'd3,   // r-format, see funct
        opAddi   = 3'd4,
        opSubi   = 3'd5
    } vsaOpcode_e;

    // r-format function field
    typedef enum logic [2:0] {
        fnAdd = 3'd0,
        fnSub = 3'd1,
        fnAnd = 3'd2,
        fnOr  = 3'd3,
        fnXor = 3'd4,
        fnNot = 3'd5,   // operand a only
        fnSrl = 3'd6,   // shift right by one, zero fill
        fnSra = 3'd7    // shift right by one, sign fill
    } vsaFunct_e;

    // instruction layout, msb first
    // i-format reuses src2 as destination and dst/funct as immediate
    typedef struct packed {
        vsaOpcode_e              opcode;
        logic [regAddrWidth-1:0] src1;
        logic [regAddrWidth-1:0] src2;
        logic [regAddrWidth-1:0] dst;
        vsaFunct_e               funct;
    } vsaInstr_t;

    // operand registers loaded in ID
    typedef struct packed {
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
    } vsaOperands_t;

    // data memory request
    typedef struct packed {
        logic [dataWidth-1:0] addr;    // result register
        logic [dataWidth-1:0] wdata;   // store data
        logic                 wr;      // write strobe
    } vsaMemReq_t;

    // 5-bit immediate from the low fields
    function automatic logic [dataWidth-1:0] immOf(vsaInstr_t instr);
        return {instr.dst, instr.funct};
    endfunction

endpackage

/* hw/vsaAlu.sv */
// vsa arithmetic unit
`timescale 1ns/1ps

module vsaAlu
    import vsaPkg::*;
(
    input  vsaInstr_t            instr,
    input  vsaOperands_t         operands,
    output logic [dataWidth-1:0] aluResult
);

    logic [dataWidth-1:0] imm;   // i-format immediate
    logic [dataWidth-1:0] a;
    logic [dataWidth-1:0] b;

    assign imm = immOf(instr);
    assign a   = operands.a;
    assign b   = operands.b;

    // execute-stage result, registered by the datapath
    always_comb begin
        case (instr.opcode)
            opLw,
            opSw:     aluResult = a + imm;   // effective address
            opAddi:   aluResult = a + imm;
            opSubi:   aluResult = a - imm;
            opAluReg: begin
                case (instr.funct)
                    fnAdd:   aluResult = a + b;
                    fnSub:   aluResult = a - b;
                    fnAnd:   aluResult = a & b;
                    fnOr:    aluResult = a | b;
                    fnXor:   aluResult = a ^ b;
                    fnNot:   aluResult = ~a;
                    fnSrl:   aluResult = {1'b0, a[dataWidth-1:1]};
                    fnSra:   aluResult = {a[dataWidth-1], a[dataWidth-1:1]};
                    default: aluResult = '0;
                endcase
            end
            default:  aluResult = '0;   // beqz and unused opcodes
        endcase
    end

    // no clock here, so check once the inputs have settled
    always_comb begin
        if (instr.opcode inside {opLw, opSw, opBeqz, opAluReg, opAddi, opSubi}) begin
            aluDefined : assert final (!$isunknown(aluResult))
                else $error("vsaAlu result unknown for opcode %0d", instr.opcode);
        end
    end

endmodule

/* hw/vsaBranchUnit.sv */
// vsa branch unit
`timescale 1ns/1ps

module vsaBranchUnit
    import vsaPkg::*;
(
    input  logic                 clock,
    input  logic                 rstN,
    input  vsaState_e            state,
    input  vsaInstr_t            instr,
    input  logic [dataWidth-1:0] operandA,
    output logic [pcWidth-1:0]   branchTarget,
    output logic [pcWidth-1:0]   pc
);

    logic [pcWidth-1:0]   nextPc;   // fall-through address
    logic                 cond;     // beqz taken
    logic [dataWidth-1:0] imm;
    logic                 isBeqz;

    assign imm    = immOf(instr);
    assign isBeqz = instr.opcode == opBeqz;

    // fall-through plus twice the low four immediate bits
    assign branchTarget = nextPc + {imm[3:0], 1'b0};

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc     <= '0;
            nextPc <= '0;
            cond   <= 1'b0;
        end else begin
            case (state)
                IF: begin
                    nextPc <= pc + pcWidth'(pcStep);
                end
                EX: begin
                    cond <= isBeqz && (operandA == '0);   // cleared for anything else
                end
                MEM: begin
                    // pc held from here through the next fetch
                    if (cond) begin
                        pc <= branchTarget;
                    end else begin
                        pc <= nextPc;
                    end
                end
                default: begin
                    // ID and WB leave the pc path alone
                end
            endcase
        end
    end

    // pc update in MEM must have taken the fall-through path
    pcFallThrough : assert property (
        @(posedge clock) disable iff (!rstN)
        (state == WB && !(isBeqz && cond)) |-> pc == nextPc
    ) else $error("vsaBranchUnit pc %0d differs from nextPc %0d in WB", pc, nextPc);

endmodule

/* hw/vsaDatapath.sv */
// vsa datapath and sequencer
`timescale 1ns/1ps

module vsaDatapath
    import vsaPkg::*;
(
    input  logic                  clock,
    input  logic                  rstN,
    input  logic [instrWidth-1:0] instruction,    // from instruction memory
    input  logic [dataWidth-1:0]  datain,         // load data
    input  logic [dataWidth-1:0]  aluResult,
    input  logic [pcWidth-1:0]    branchTarget,
    output vsaState_e             state,
    output vsaInstr_t             instr,
    output vsaOperands_t          operands,
    output vsaMemReq_t            memReq
);

    logic [dataWidth-1:0]    regFile [regCount];   // r0 kept at zero
    logic [dataWidth-1:0]    result;               // execute result register
    logic [dataWidth-1:0]    loadData;             // load data register
    vsaState_e               stateNext;

    // write-back decode
    logic                    isAluReg;
    logic                    isImm;
    logic                    isLoad;
    logic                    wrEn;
    logic [regAddrWidth-1:0] wrAddr;
    logic [dataWidth-1:0]    wrData;

    // fixed five-state ring
    always_comb begin
        case (state)
            IF:      stateNext = ID;
            ID:      stateNext = EX;
            EX:      stateNext = MEM;
            MEM:     stateNext = WB;
            default: stateNext = IF;   // WB wraps
        endcase
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= IF;
        end else begin
            state <= stateNext;
        end
    end

    // instruction, operand, result and load registers
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            instr    <= '0;
            operands <= '0;
            result   <= '0;
            loadData <= '0;
        end else begin
            case (state)
                IF: begin
                    instr <= vsaInstr_t'(instruction);   // memory answers within IF
                end
                ID: begin
                    operands.a <= regFile[instr.src1];
                    operands.b <= regFile[instr.src2];
                end
                EX: begin
                    // branch target rides the result register for beqz
                    if (instr.opcode == opBeqz) begin
                        result <= branchTarget;
                    end else begin
                        result <= aluResult;
                    end
                end
                MEM: begin
                    if (isLoad) begin
                        loadData <= datain;
                    end
                end
                default: begin
                    // WB only touches the register file
                end
            endcase
        end
    end

    assign isAluReg = instr.opcode == opAluReg;
    assign isImm    = instr.opcode inside {opAddi, opSubi};
    assign isLoad   = instr.opcode == opLw;

    // destination select, r-format uses dst, i-format uses src2
    always_comb begin
        wrEn   = 1'b0;
        wrAddr = instr.src2;
        wrData = result;
        if (isAluReg) begin
            wrEn   = 1'b1;
            wrAddr = instr.dst;
        end else if (isImm) begin
            wrEn   = 1'b1;
        end else if (isLoad) begin
            wrEn   = 1'b1;
            wrData = loadData;
        end
        if (wrAddr == '0) begin
            wrEn = 1'b0;   // r0 writes dropped
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regFile[i] <= '0;
            end
        end else if (state == WB && wrEn) begin
            regFile[wrAddr] <= wrData;
        end
    end

    // data memory request
    assign memReq.addr  = result;
    assign memReq.wdata = operands.b;
    assign memReq.wr    = (state == MEM) && (instr.opcode == opSw);

    r0Zero : assert property (
        @(posedge clock) disable iff (!rstN)
        regFile[0] == '0
    ) else $error("vsaDatapath r0 holds %0d", regFile[0]);

    // single-cycle strobe, only in MEM
    wrInMem : assert property (
        @(posedge clock) disable iff (!rstN)
        memReq.wr |-> state == MEM ##1 (state == WB && !memReq.wr)
    ) else $error("vsaDatapath write strobe outside MEM");

endmodule

/* hw/vsaCpu.sv */
// vsa processor top
`timescale 1ns/1ps

module vsaCpu
    import vsaPkg::*;
(
    input  logic                  clock,
    input  logic                  rstN,
    output logic [pcWidth-1:0]    pc,            // fetch address
    input  logic [instrWidth-1:0] instruction,
    output vsaMemReq_t            memReq,        // data memory request
    input  logic [dataWidth-1:0]  datain         // load data
);

    vsaState_e            state;
    vsaInstr_t            instr;
    vsaOperands_t         operands;
    logic [dataWidth-1:0] aluResult;      // combinational execute result
    logic [pcWidth-1:0]   branchTarget;   // beqz destination

    // sequencer, registers and write-back
    vsaDatapath u_datapath (
        .clock        (clock),
        .rstN         (rstN),
        .instruction  (instruction),
        .datain       (datain),
        .aluResult    (aluResult),
        .branchTarget (branchTarget),
        .state        (state),
        .instr        (instr),
        .operands     (operands),
        .memReq       (memReq)
    );

    vsaAlu u_alu (
        .instr     (instr),
        .operands  (operands),
        .aluResult (aluResult)
    );

    // pc and branch condition
    vsaBranchUnit u_branchUnit (
        .clock        (clock),
        .rstN         (rstN),
        .state        (state),
        .instr        (instr),
        .operandA     (operands.a),
        .branchTarget (branchTarget),
        .pc           (pc)
    );

endmodule

/* bench/vsaClockGen.sv */
// testbench clock and reset
`timescale 1ns/1ps

module vsaClockGen (
    output logic clock,
    output logic rstN
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;   // 10 ns period
    end

    // low across three rising edges, released right after the third
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clock);
        rstN <= 1'b1;   // first IF follows
    end

endmodule

/* bench/vsaTb.sv */
// vsa processor testbench
`timescale 1ns/1ps

module vsaTb
    import vsaPkg::*;
();

    // one executed instruction and what it should produce
    typedef struct packed {
        logic [instrWidth-1:0] instr;
        logic [dataWidth-1:0]  loadData;   // returned on datain, used by LW
        logic [pcWidth-1:0]    nextPc;     // pc expected in the following IF
        vsaMemReq_t            expReq;     // addr and wdata only meaningful for SW
    } stepRow_t;

    logic                  clock;
    logic                  rstN;
    logic [pcWidth-1:0]    pc;
    logic [instrWidth-1:0] instruction;
    vsaMemReq_t            memReq;
    logic [dataWidth-1:0]  datain;

    stepRow_t              imem [16];      // instruction memory, row = pc / 2
    stepRow_t              steps [27];     // directed program in execution order
    vsaMemReq_t            idleReq = '0;
    logic [pcWidth-1:0]    expPc;
    int                    seed;

    vsaClockGen u_clockGen (
        .clock (clock),
        .rstN  (rstN)
    );

    vsaCpu u_vsaCpu (
        .clock       (clock),
        .rstN        (rstN),
        .pc          (pc),
        .instruction (instruction),
        .memReq      (memReq),
        .datain      (datain)
    );

    task automatic stopOnFailure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // wr always checked, addr and wdata only when a store is expected
    task automatic compareMemReq(input vsaMemReq_t got, input vsaMemReq_t exp);
        if (got.wr !== exp.wr
            || (exp.wr && (got.addr !== exp.addr || got.wdata !== exp.wdata))) begin
            $display("mismatch time %0t: memReq addr/wdata/wr got %0d/%0d/%b expected %0d/%0d/%b",
                     $time, got.addr, got.wdata, got.wr, exp.addr, exp.wdata, exp.wr);
            stopOnFailure();
        end
    endtask

    task automatic comparePc(input logic [pcWidth-1:0] got, input logic [pcWidth-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at time %0t: pc got %0d expected %0d", $time, got, exp);
            stopOnFailure();
        end
    endtask

    function automatic logic [instrWidth-1:0] encodeImm(
        input logic [2:0]           op,
        input logic [1:0]           src1,
        input logic [1:0]           src2,
        input logic [dataWidth-1:0] imm
    );
        return {op, src1, src2, imm};   // imm fills dst and funct
    endfunction

    function automatic logic [instrWidth-1:0] encodeReg(
        input logic [1:0] src1,
        input logic [1:0] src2,
        input logic [1:0] dst,
        input vsaFunct_e  fn
    );
        return {opAluReg, src1, src2, dst, fn};
    endfunction

    function automatic vsaMemReq_t storeReq(
        input logic [dataWidth-1:0] addr,
        input logic [dataWidth-1:0] data
    );
        vsaMemReq_t req;
        req.addr  = addr;
        req.wdata = data;
        req.wr    = 1'b1;
        return req;
    endfunction

    function automatic stepRow_t makeRow(
        input logic [instrWidth-1:0] instr,
        input logic [dataWidth-1:0]  load,
        input logic [pcWidth-1:0]    nextPc,
        input vsaMemReq_t            req
    );
        stepRow_t row;
        row.instr    = instr;
        row.loadData = load;
        row.nextPc   = nextPc;
        row.expReq   = req;
        return row;
    endfunction

    // register values noted after each step
    task automatic loadTable();
        steps[0]  = makeRow(encodeImm(opAddi, 2'd0, 2'd1, 5'd5), 5'd0, 5'd2, idleReq);   // r1 5
        steps[1]  = makeRow(encodeImm(opSubi, 2'd1, 2'd2, 5'd3), 5'd0, 5'd4, idleReq);   // r2 2
        steps[2]  = makeRow(encodeImm(opSw, 2'd1, 2'd2, 5'd4), 5'd0, 5'd6, storeReq(5'd9, 5'd2));
        steps[3]  = makeRow(encodeImm(opAddi, 2'd1, 2'd0, 5'd7), 5'd0, 5'd8, idleReq);   // to r0
        steps[4]  = makeRow(encodeImm(opSw, 2'd0, 2'd0, 5'd1), 5'd0, 5'd10, storeReq(5'd1, 5'd0));
        steps[5]  = makeRow(encodeImm(opAddi, 2'd0, 2'd3, 5'd22), 5'd0, 5'd12, idleReq);  // r3 22
        steps[6]  = makeRow(encodeReg(2'd3, 2'd1, 2'd2, fnAdd), 5'd0, 5'd14, idleReq);    // r2 27
        steps[7]  = makeRow(encodeReg(2'd3, 2'd1, 2'd1, fnSub), 5'd0, 5'd16, idleReq);    // r1 17
        steps[8]  = makeRow(encodeImm(opSw, 2'd2, 2'd1, 5'd0), 5'd0, 5'd18, storeReq(5'd27, 5'd17));
        steps[9]  = makeRow(encodeReg(2'd3, 2'd1, 2'd2, fnAnd), 5'd0, 5'd20, idleReq);    // r2 16
        steps[10] = makeRow(encodeReg(2'd3, 2'd1, 2'd1, fnOr), 5'd0, 5'd22, idleReq);     // r1 23
        steps[11] = makeRow(encodeImm(opSw, 2'd2, 2'd1, 5'd0), 5'd0, 5'd24, storeReq(5'd16, 5'd23));
        steps[12] = makeRow(encodeReg(2'd3, 2'd1, 2'd2, fnXor), 5'd0, 5'd26, idleReq);    // r2 1
        steps[13] = makeRow(encodeReg(2'd3, 2'd1, 2'd1, fnNot), 5'd0, 5'd28, idleReq);    // r1 9
        steps[14] = makeRow(encodeImm(opSw, 2'd2, 2'd1, 5'd0), 5'd0, 5'd30, storeReq(5'd1, 5'd9));
        steps[15] = makeRow(encodeReg(2'd3, 2'd0, 2'd2, fnSrl), 5'd0, 5'd0, idleReq);     // r2 11
        steps[16] = makeRow(encodeReg(2'd3, 2'd0, 2'd1, fnSra), 5'd0, 5'd2, idleReq);     // r1 27
        steps[17] = makeRow(encodeImm(opSw, 2'd2, 2'd1, 5'd0), 5'd0, 5'd4, storeReq(5'd11, 5'd27));
        steps[18] = makeRow(encodeImm(opLw, 2'd2, 2'd3, 5'd3), 5'd13, 5'd6, idleReq);     // r3 13
        steps[19] = makeRow(encodeImm(opSw, 2'd0, 2'd3, 5'd2), 5'd0, 5'd8, storeReq(5'd2, 5'd13));
        steps[20] = makeRow(encodeImm(opBeqz, 2'd0, 2'd0, 5'd3), 5'd0, 5'd16, idleReq);   // taken
        steps[21] = makeRow(encodeImm(opBeqz, 2'd2, 2'd0, 5'd5), 5'd0, 5'd18, idleReq);   // r2 11
        steps[22] = makeRow(encodeImm(3'd6, 2'd1, 2'd1, 5'd31), 5'd0, 5'd20, idleReq);
        steps[23] = makeRow(encodeImm(3'd7, 2'd2, 2'd3, 5'd9), 5'd0, 5'd22, idleReq);
        steps[24] = makeRow(encodeImm(opBeqz, 2'd0, 2'd0, 5'd18), 5'd0, 5'd28, idleReq);  // bit 4 ignored
        steps[25] = makeRow(encodeImm(opSubi, 2'd0, 2'd2, 5'd1), 5'd0, 5'd30, idleReq);   // r2 31
        steps[26] = makeRow(encodeImm(opSw, 2'd2, 2'd3, 5'd4), 5'd0, 5'd0, storeReq(5'd3, 5'd13));
    endtask

    task automatic waitReset();
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (cycles > 20) begin
                $display("reset was never released after %0d cycles", cycles);
                stopOnFailure();
            end
        end
    endtask

    // entered on the falling edge inside IF, leaves on the next IF
    task automatic runStep(input stepRow_t row);
        logic [3:0] slot;
        slot        = pc[4:1];   // pc / 2
        imem[slot]  = row;
        instruction = imem[slot].instr;
        datain      = imem[slot].loadData;
        compareMemReq(memReq, idleReq);      // IF
        @(negedge clock);
        compareMemReq(memReq, idleReq);      // ID
        @(negedge clock);
        compareMemReq(memReq, idleReq);      // EX
        @(negedge clock);
        compareMemReq(memReq, row.expReq);   // MEM
        @(negedge clock);
        compareMemReq(memReq, idleReq);      // WB
        @(negedge clock);
        comparePc(pc, row.nextPc);
        expPc = row.nextPc;
    endtask

    task automatic randomSweep();
        logic [dataWidth-1:0] shadow [regCount];
        logic [31:0]          rnd;
        logic [1:0]           dstReg;
        logic [1:0]           srcReg;
        logic [1:0]           baseReg;
        logic [dataWidth-1:0] immA;
        logic [dataWidth-1:0] immB;
        // registers as the directed program leaves them
        shadow[0] = 5'd0;
        shadow[1] = 5'd27;
        shadow[2] = 5'd31;
        shadow[3] = 5'd13;
        for (int i = 0; i < 8; i++) begin
            rnd     = $random(seed);
            dstReg  = (rnd[1:0] == 2'd0) ? 2'd1 : rnd[1:0];   // keep the write visible
            srcReg  = rnd[3:2];
            baseReg = rnd[5:4];
            immA    = rnd[10:6];
            immB    = rnd[15:11];
            shadow[dstReg] = shadow[srcReg] + immA;
            runStep(makeRow(encodeImm(opAddi, srcReg, dstReg, immA), 5'd0,
                            expPc + 5'd2, idleReq));
            // store back through a random base register
            runStep(makeRow(encodeImm(opSw, baseReg, dstReg, immB), 5'd0, expPc + 5'd2,
                            storeReq(shadow[baseReg] + immB, shadow[dstReg])));
        end
    endtask

    initial begin
        instruction = '0;
        datain      = '0;
        seed        = 32'h83e2_d823;
        loadTable();
        waitReset();
        expPc = '0;
        comparePc(pc, expPc);   // reset value
        for (int i = 0; i < $size(steps); i++) begin
            runStep(steps[i]);
        end
        randomSweep();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* sim.f */
hw/vsaPkg.sv
hw/vsaAlu.sv
hw/vsaBranchUnit.sv
hw/vsaDatapath.sv
hw/vsaCpu.sv
bench/vsaClockGen.sv
bench/vsaTb.sv

/* runSim.sh */
#!/bin/sh
# build and run the vsa testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps --top-module vsaTb -f sim.f -o vsaSim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/vsaSim > sim.log 2>&1
cat sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "simulation reported errors"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation clean"
